// ==== Bender.yml ====
package:
  name: mips_pipe

sources:
  - design/cpu_types_pkg.sv
  - design/pipe_types_pkg.sv
  - design/control_unit.sv
  - design/register_file.sv
  - design/alu.sv
  - design/pipeline_reg.sv
  - design/datapath.sv
  - design/mem_arbiter.sv
  - design/mips_core.sv
  - target: test
    files:
      - dv/tb_ram.sv
      - dv/tb_mips_core.sv

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu
  import cpu_types_pkg::*;
(
  input  aluop_t     alu_op,
  input  word_t      port_a,
  input  word_t      port_b,
  input  logic [4:0] shamt,
  output word_t      out,
  output logic       zero
);

  always_comb begin
    case (alu_op)
      // shifts move port_b, as in sll rd, rt, shamt
      ALU_SLL:  out = port_b << shamt;
      ALU_SRL:  out = port_b >> shamt;
      ALU_ADD:  out = port_a + port_b;
      ALU_SUB:  out = port_a - port_b;
      ALU_AND:  out = port_a & port_b;
      ALU_OR:   out = port_a | port_b;
      ALU_XOR:  out = port_a ^ port_b;
      ALU_NOR:  out = ~(port_a | port_b);
      ALU_SLT:  out = {31'd0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: out = {31'd0, port_a < port_b};
      default:  out = '0;
    endcase
  end

  // used by beq and bne
  assign zero = (out == '0);

endmodule

// ==== design/control_unit.sv ====
`timescale 1ns/10ps

module control_unit
  import cpu_types_pkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl
);

  r_t instr_r;

  assign instr_r = instr;

  always_comb begin
    // nop unless the opcode says otherwise
    ctrl = '0;
    case (instr_r.opcode)
      RTYPE: begin
        ctrl.reg_dst = DST_RD;
        ctrl.reg_wr  = 1'b1;
        case (instr_r.funct)
          SLL:  ctrl.alu_op = ALU_SLL;
          SRL:  ctrl.alu_op = ALU_SRL;
          ADDU: ctrl.alu_op = ALU_ADD;
          SUBU: ctrl.alu_op = ALU_SUB;
          AND:  ctrl.alu_op = ALU_AND;
          OR:   ctrl.alu_op = ALU_OR;
          XOR:  ctrl.alu_op = ALU_XOR;
          NOR:  ctrl.alu_op = ALU_NOR;
          SLT:  ctrl.alu_op = ALU_SLT;
          SLTU: ctrl.alu_op = ALU_SLTU;
          JR: begin
            ctrl.jreg   = 1'b1;
            ctrl.reg_wr = 1'b0;
          end
          default: ctrl.reg_wr = 1'b0;
        endcase
      end
      ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.ext     = EXT_SIGN;
        case (instr_r.opcode)
          ADDIU:   ctrl.alu_op = ALU_ADD;
          SLTI:    ctrl.alu_op = ALU_SLT;
          // sltiu still sign-extends, compare is unsigned
          SLTIU:   ctrl.alu_op = ALU_SLTU;
          ANDI:    {ctrl.alu_op, ctrl.ext} = {ALU_AND, EXT_ZERO};
          ORI:     {ctrl.alu_op, ctrl.ext} = {ALU_OR, EXT_ZERO};
          XORI:    {ctrl.alu_op, ctrl.ext} = {ALU_XOR, EXT_ZERO};
          default: {ctrl.alu_op, ctrl.ext} = {ALU_OR, EXT_UPPER};
        endcase
      end
      LW: begin
        {ctrl.alu_src, ctrl.alu_op, ctrl.ext} = {1'b1, ALU_ADD, EXT_SIGN};
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_wr     = 1'b1;
      end
      SW: begin
        {ctrl.alu_src, ctrl.alu_op, ctrl.ext} = {1'b1, ALU_ADD, EXT_SIGN};
        ctrl.mem_wr = 1'b1;
      end
      // zero flag from rs - rt, offset sign-extended
      BEQ: {ctrl.alu_op, ctrl.ext, ctrl.beq} = {ALU_SUB, EXT_SIGN, 1'b1};
      BNE: {ctrl.alu_op, ctrl.ext, ctrl.bne} = {ALU_SUB, EXT_SIGN, 1'b1};
      J:   ctrl.jump = 1'b1;
      JAL: begin
        ctrl.jump    = 1'b1;
        ctrl.jal     = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = DST_RA;
      end
      HALT:    ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== design/cpu_types_pkg.sv ====
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  // alu_sll is zero so a cleared stage reads as a plain nop
  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regdst_t;
  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} ext_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    logic [15:0] imm;
  } i_t;

  typedef struct packed {
    opcode_t opcode;
    logic [25:0] addr;
  } j_t;

  typedef struct packed {
    regdst_t reg_dst;
    logic    alu_src;
    aluop_t  alu_op;
    ext_t    ext;
    logic    mem_wr;
    logic    mem_to_reg;
    logic    beq;
    logic    bne;
    logic    jump;
    logic    jreg;
    logic    jal;
    logic    reg_wr;
    logic    halt;
  } ctrl_t;

endpackage

// ==== design/datapath.sv ====
`timescale 1ns/10ps

module datapath
  import cpu_types_pkg::*;
  import pipe_types_pkg::*;
#(
  parameter word_t PC_INIT = '0
) (
  input  logic    CLK,
  input  logic    nRST,
  input  dp_rsp_t dp_rsp,
  output dp_req_t dp_req,
  output logic    halt
);

  if_id_t   if_id_in, if_id;
  id_ex_t   id_ex_in, id_ex;
  ex_mem_t  ex_mem_in, ex_mem;
  mem_wb_t  mem_wb_in, mem_wb;
  ctrl_t    id_ctrl;
  i_t       id_i;
  r_t       ex_r;
  j_t       ex_j;
  word_t    pc, pc_p4, npc;
  word_t    rdat1, rdat2, id_imm;
  word_t    alu_b, alu_out, wdat;
  logic     alu_zero;
  regbits_t wr_dest;
  logic     stop;

  control_unit cu0 (.instr(if_id.instr), .ctrl(id_ctrl));

  register_file rf0 (
    .CLK(CLK), .nRST(nRST),
    .wen(mem_wb.reg_wr), .wsel(mem_wb.wr_dest),
    .rsel1(id_i.rs), .rsel2(id_i.rt),
    .wdat(wdat), .rdat1(rdat1), .rdat2(rdat2)
  );

  alu alu0 (
    .alu_op(id_ex.ctrl.alu_op), .port_a(id_ex.rdat1), .port_b(alu_b),
    .shamt(ex_r.shamt), .out(alu_out), .zero(alu_zero)
  );

  pipeline_reg pr0 (
    .CLK(CLK), .nRST(nRST), .ihit(dp_rsp.ihit), .dhit(dp_rsp.dhit),
    .if_id_in(if_id_in), .id_ex_in(id_ex_in),
    .ex_mem_in(ex_mem_in), .mem_wb_in(mem_wb_in),
    .if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb)
  );

  // IF
  assign pc_p4    = pc + 32'd4;
  assign if_id_in = '{instr: dp_rsp.imemload, npc: pc_p4};

  // jumps and branches resolve from the MEM stage, three slots behind
  always_comb begin
    npc = pc_p4;
    if (ex_mem.ctrl.jump) begin
      npc = ex_mem.jump_addr;
    end else if (ex_mem.ctrl.jreg) begin
      npc = ex_mem.rdat1;
    end else if ((ex_mem.ctrl.beq && ex_mem.zero) || (ex_mem.ctrl.bne && !ex_mem.zero)) begin
      npc = ex_mem.branch_addr;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (dp_rsp.ihit) begin
      pc <= npc;
    end
  end

  // ID
  assign id_i = if_id.instr;

  always_comb begin
    case (id_ctrl.ext)
      EXT_SIGN:  id_imm = {{16{id_i.imm[15]}}, id_i.imm};
      EXT_UPPER: id_imm = {id_i.imm, 16'h0000};
      default:   id_imm = {16'h0000, id_i.imm};
    endcase
  end

  assign id_ex_in = '{ctrl: id_ctrl, npc: if_id.npc, rdat1: rdat1, rdat2: rdat2,
                      imm: id_imm, rt: id_i.rt, rd: if_id.instr[15:11],
                      instr: if_id.instr};

  // EX
  assign ex_r  = id_ex.instr;
  assign ex_j  = id_ex.instr;
  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rdat2;

  always_comb begin
    case (id_ex.ctrl.reg_dst)
      DST_RD:  wr_dest = id_ex.rd;
      DST_RA:  wr_dest = 5'd31;
      default: wr_dest = id_ex.rt;
    endcase
  end

  assign ex_mem_in = '{ctrl: id_ex.ctrl, npc: id_ex.npc, rdat1: id_ex.rdat1,
                       rdat2: id_ex.rdat2, alu_out: alu_out, zero: alu_zero,
                       branch_addr: id_ex.npc + {id_ex.imm[29:0], 2'b00},
                       jump_addr: {id_ex.npc[31:28], ex_j.addr, 2'b00},
                       wr_dest: wr_dest};

  // MEM
  assign mem_wb_in = '{reg_wr: ex_mem.ctrl.reg_wr, mem_to_reg: ex_mem.ctrl.mem_to_reg,
                       jal: ex_mem.ctrl.jal, halt: ex_mem.ctrl.halt, npc: ex_mem.npc,
                       alu_out: ex_mem.alu_out, dmemload: dp_rsp.dmemload,
                       wr_dest: ex_mem.wr_dest};

  // halt in WB already shuts the ports, the flop keeps them shut
  assign stop = halt | mem_wb.halt;

  assign dp_req.imem_ren   = !stop;
  assign dp_req.imem_addr  = pc;
  assign dp_req.dmem_ren   = ex_mem.ctrl.mem_to_reg & !stop;
  assign dp_req.dmem_wen   = ex_mem.ctrl.mem_wr & !stop;
  assign dp_req.dmem_addr  = ex_mem.alu_out;
  assign dp_req.dmem_store = ex_mem.rdat2;

  // WB, link address for jal
  assign wdat = mem_wb.jal ? mem_wb.npc : (mem_wb.mem_to_reg ? mem_wb.dmemload : mem_wb.alu_out);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (mem_wb.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter
  import cpu_types_pkg::*;
  import pipe_types_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  dp_req_t  dp_req,
  output dp_rsp_t  dp_rsp,
  output ram_req_t ram_req,
  input  word_t    ram_load,
  input  logic     ram_ready
);

  typedef enum logic {IDLE, DATA_DONE} arb_state_t;

  arb_state_t state;
  logic       data_req, data_grant, fetch_grant;

  assign data_req = dp_req.dmem_ren | dp_req.dmem_wen;

  // data first, except right after a data hit
  assign data_grant  = data_req && ((state == IDLE) || !dp_req.imem_ren);
  assign fetch_grant = dp_req.imem_ren && !data_grant;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else if (dp_rsp.dhit) begin
      state <= DATA_DONE;
    end else if (dp_rsp.ihit || !dp_req.imem_ren) begin
      state <= IDLE;
    end
  end

  assign ram_req.ren   = data_grant ? dp_req.dmem_ren : fetch_grant;
  assign ram_req.wen   = data_grant & dp_req.dmem_wen;
  assign ram_req.addr  = data_grant ? dp_req.dmem_addr : dp_req.imem_addr;
  assign ram_req.store = dp_req.dmem_store;

  assign dp_rsp.ihit     = fetch_grant & ram_ready;
  assign dp_rsp.dhit     = data_grant & ram_ready;
  assign dp_rsp.imemload = ram_load;
  assign dp_rsp.dmemload = ram_load;

endmodule

// ==== design/mips_core.sv ====
`timescale 1ns/10ps

module mips_core
  import cpu_types_pkg::*;
  import pipe_types_pkg::*;
#(
  parameter word_t PC_INIT = '0
) (
  input  logic     CLK,
  input  logic     nRST,
  output ram_req_t ram_req,
  input  word_t    ram_load,
  input  logic     ram_ready,
  output logic     halt
);

  dp_req_t dp_req;
  dp_rsp_t dp_rsp;

  datapath #(.PC_INIT(PC_INIT)) dp0 (
    .CLK(CLK), .nRST(nRST),
    .dp_rsp(dp_rsp), .dp_req(dp_req), .halt(halt)
  );

  // one RAM port shared by fetch and data
  mem_arbiter arb0 (
    .CLK(CLK), .nRST(nRST),
    .dp_req(dp_req), .dp_rsp(dp_rsp),
    .ram_req(ram_req), .ram_load(ram_load), .ram_ready(ram_ready)
  );

endmodule

// ==== design/pipe_types_pkg.sv ====
package pipe_types_pkg;
  import cpu_types_pkg::*;

  typedef struct packed {
    word_t instr;
    word_t npc;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    npc;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regbits_t rt;
    regbits_t rd;
    word_t    instr;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    npc;
    word_t    rdat1;
    word_t    rdat2;
    word_t    alu_out;
    logic     zero;
    word_t    branch_addr;
    word_t    jump_addr;
    regbits_t wr_dest;
  } ex_mem_t;

  typedef struct packed {
    logic     reg_wr;
    logic     mem_to_reg;
    logic     jal;
    logic     halt;
    word_t    npc;
    word_t    alu_out;
    word_t    dmemload;
    regbits_t wr_dest;
  } mem_wb_t;

  // datapath side of the arbiter
  typedef struct packed {
    logic  imem_ren;
    word_t imem_addr;
    logic  dmem_ren;
    logic  dmem_wen;
    word_t dmem_addr;
    word_t dmem_store;
  } dp_req_t;

  typedef struct packed {
    logic  ihit;
    logic  dhit;
    word_t imemload;
    word_t dmemload;
  } dp_rsp_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } ram_req_t;

endpackage

// ==== design/pipeline_reg.sv ====
`timescale 1ns/10ps

module pipeline_reg
  import pipe_types_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    ihit,
  input  logic    dhit,
  input  if_id_t  if_id_in,
  input  id_ex_t  id_ex_in,
  input  ex_mem_t ex_mem_in,
  input  mem_wb_t mem_wb_in,
  output if_id_t  if_id,
  output id_ex_t  id_ex,
  output ex_mem_t ex_mem,
  output mem_wb_t mem_wb
);

  // front half only moves with a fetch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      if_id <= '0;
      id_ex <= '0;
    end else if (ihit) begin
      if_id <= if_id_in;
      id_ex <= id_ex_in;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem <= '0;
      mem_wb <= '0;
    end else if (ihit) begin
      ex_mem <= ex_mem_in;
      mem_wb <= mem_wb_in;
    end else if (dhit) begin
      // memory op finishes early and goes on to WB by itself
      mem_wb <= mem_wb_in;
      // what stays in MEM is a bubble, so the access is not repeated
      // and the load is not written back a second time
      ex_mem.ctrl.mem_wr     <= 1'b0;
      ex_mem.ctrl.mem_to_reg <= 1'b0;
      ex_mem.ctrl.reg_wr     <= 1'b0;
    end
  end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/10ps

module register_file
  import cpu_types_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regbits_t wsel,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != '0)) begin
      // r0 stays hardwired to zero
      regs[wsel] <= wdat;
    end
  end

  // no write-through, a reader in the same cycle sees the old value
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

// ==== dv/tb_mips_core.sv ====
`timescale 1ns/10ps

module tb_mips_core
  import cpu_types_pkg::*;
  import pipe_types_pkg::*;
();

  localparam int    CLK_PERIOD = 100;
  localparam int    MAX_DELAY  = 3;
  localparam word_t DATA_BASE  = 32'h0000_0800;
  localparam word_t A = 32'h1234_5678;
  localparam word_t B = 32'hF0F0_0F0F;
  localparam word_t C = 32'hFFFF_FFFB;
  localparam word_t MARK = 32'h0000_00A5;

  logic     CLK;
  logic     nRST;
  ram_req_t ram_req;
  word_t    ram_load;
  logic     ram_ready;
  logic     halt;

  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  string exp_name [$];
  int    slot = 0;
  int    errors = 0;
  int    checks = 0;
  int    timeout_cycles = 0;
  logic  halt_seen = 1'b0;
  word_t ea, ed;
  string en;

  mips_core #(.PC_INIT(32'd0)) dut0 (
    .CLK(CLK), .nRST(nRST), .ram_req(ram_req),
    .ram_load(ram_load), .ram_ready(ram_ready), .halt(halt)
  );

  tb_ram ram0 (.CLK(CLK), .req(ram_req), .load(ram_load), .ready(ram_ready));

  function automatic word_t r_word(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd,
                                   logic [4:0] sh);
    r_t w;
    w = '{opcode: RTYPE, rs: rs, rt: rt, rd: rd, shamt: sh, funct: f};
    return w;
  endfunction

  function automatic word_t i_word(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
    i_t w;
    w = '{opcode: op, rs: rs, rt: rt, imm: imm};
    return w;
  endfunction

  function automatic word_t j_word(opcode_t op, logic [25:0] target);
    j_t w;
    w = '{opcode: op, addr: target};
    return w;
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  // no forwarding, so three nops before a result can be read
  task automatic spaced(input word_t w);
    emit(w);
    repeat (3) emit('0);
  endtask

  task automatic store_check(input string name, input regbits_t r, input word_t val);
    word_t addr;
    addr = DATA_BASE + 4 * slot;
    slot++;
    spaced(i_word(SW, 5'd0, r, addr[15:0]));
    exp_addr.push_back(addr);
    exp_data.push_back(val);
    exp_name.push_back(name);
  endtask

  // marker store of r7 that is expected only on the path that should run
  task automatic mark(input string name, input bit on_path);
    word_t addr;
    addr = DATA_BASE + 4 * slot;
    slot++;
    emit(i_word(SW, 5'd0, 5'd7, addr[15:0]));
    if (on_path) begin
      exp_addr.push_back(addr);
      exp_data.push_back(MARK);
      exp_name.push_back(name);
    end
  endtask

  // branch at b with delay slots b+1 to b+3, fall-through b+4 and target b+5
  task automatic branch_case(input string name, input word_t br, input bit taken,
                             input bit slot_mark);
    emit(br);
    for (int i = 1; i <= 3; i++) begin
      if (slot_mark) begin
        mark($sformatf("%s delay slot %0d", name, i), 1'b1);
      end else begin
        emit('0);
      end
    end
    mark({name, " fall-through"}, !taken);
    mark({name, " target"}, 1'b1);
  endtask

  task automatic build_program();
    int idx;
    spaced(i_word(LUI, 5'd0, 5'd1, A[31:16]));
    spaced(i_word(ORI, 5'd1, 5'd1, A[15:0]));
    spaced(i_word(LUI, 5'd0, 5'd2, B[31:16]));
    spaced(i_word(ORI, 5'd2, 5'd2, B[15:0]));
    spaced(i_word(ADDIU, 5'd0, 5'd7, MARK[15:0]));
    spaced(i_word(ADDIU, 5'd0, 5'd3, 16'hFFFB));
    store_check("addiu sign", 5'd3, C);
    spaced(r_word(ADDU, 5'd1, 5'd2, 5'd4, 5'd0));
    store_check("addu", 5'd4, A + B);
    spaced(r_word(SUBU, 5'd1, 5'd2, 5'd4, 5'd0));
    store_check("subu", 5'd4, A - B);
    spaced(r_word(AND, 5'd1, 5'd2, 5'd4, 5'd0));
    store_check("and", 5'd4, A & B);
    spaced(r_word(OR, 5'd1, 5'd2, 5'd4, 5'd0));
    store_check("or", 5'd4, A | B);
    spaced(r_word(XOR, 5'd1, 5'd2, 5'd4, 5'd0));
    store_check("xor", 5'd4, A ^ B);
    spaced(r_word(NOR, 5'd1, 5'd2, 5'd4, 5'd0));
    store_check("nor", 5'd4, ~(A | B));
    spaced(r_word(SLT, 5'd2, 5'd1, 5'd4, 5'd0));
    store_check("slt", 5'd4, ($signed(B) < $signed(A)) ? 32'd1 : 32'd0);
    spaced(r_word(SLTU, 5'd2, 5'd1, 5'd4, 5'd0));
    store_check("sltu", 5'd4, (B < A) ? 32'd1 : 32'd0);
    spaced(r_word(SLL, 5'd0, 5'd1, 5'd4, 5'd4));
    store_check("sll", 5'd4, A << 4);
    spaced(r_word(SRL, 5'd0, 5'd2, 5'd4, 5'd8));
    store_check("srl", 5'd4, B >> 8);
    // immediates
    spaced(i_word(ANDI, 5'd2, 5'd5, 16'hFFFF));
    store_check("andi", 5'd5, B & 32'h0000_FFFF);
    spaced(i_word(ORI, 5'd0, 5'd5, 16'h8000));
    store_check("ori", 5'd5, 32'h0000_8000);
    spaced(i_word(XORI, 5'd1, 5'd5, 16'hFFFF));
    store_check("xori", 5'd5, A ^ 32'h0000_FFFF);
    spaced(i_word(LUI, 5'd0, 5'd5, 16'h8001));
    store_check("lui", 5'd5, 32'h8001_0000);
    spaced(i_word(SLTI, 5'd0, 5'd5, 16'hFFFC));
    store_check("slti", 5'd5, (0 < -4) ? 32'd1 : 32'd0);
    spaced(i_word(SLTIU, 5'd3, 5'd5, 16'hFFFC));
    store_check("sltiu neg", 5'd5, (C < 32'hFFFF_FFFC) ? 32'd1 : 32'd0);
    spaced(i_word(SLTIU, 5'd3, 5'd5, 16'd5));
    store_check("sltiu pos", 5'd5, (C < 32'd5) ? 32'd1 : 32'd0);
    // load/store round trip through the slot just written
    store_check("sw src", 5'd1, A);
    spaced(i_word(LW, 5'd0, 5'd6, 16'(DATA_BASE + 4 * (slot - 1))));
    store_check("lw copy", 5'd6, A);
    spaced(i_word(ADDIU, 5'd0, 5'd0, 16'd7));
    store_check("r0 zero", 5'd0, 32'd0);
    // branch offset 4 lands on b+5
    branch_case("beq taken", i_word(BEQ, 5'd1, 5'd1, 16'd4), 1'b1, 1'b1);
    branch_case("beq not taken", i_word(BEQ, 5'd1, 5'd2, 16'd4), 1'b0, 1'b0);
    branch_case("bne taken", i_word(BNE, 5'd1, 5'd2, 16'd4), 1'b1, 1'b0);
    branch_case("bne not taken", i_word(BNE, 5'd1, 5'd1, 16'd4), 1'b0, 1'b0);
    idx = prog.size();
    branch_case("j", j_word(J, 26'(idx + 5)), 1'b1, 1'b0);
    idx = prog.size();
    branch_case("jal", j_word(JAL, 26'(idx + 5)), 1'b1, 1'b0);
    store_check("jal link", 5'd31, word_t'((idx + 1) * 4));
    idx = prog.size();
    spaced(i_word(ADDIU, 5'd0, 5'd8, 16'((idx + 4 + 5) * 4)));
    branch_case("jr", r_word(JR, 5'd8, 5'd0, 5'd0, 5'd0), 1'b1, 1'b0);
    emit(j_word(HALT, 26'd0));
    repeat (4) emit('0);
  endtask

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    wait (timeout_cycles != 0);
    repeat (timeout_cycles) @(posedge CLK);
    errors++;
    $display("watchdog expired, halt not reached after %0d cycles", timeout_cycles);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

  // every completed write is checked against the expected list in order
  always @(posedge CLK) begin
    if (nRST && ram_req.wen && ram_ready) begin
      checks++;
      if (exp_addr.size() == 0) begin
        $display("store of %h to %h seen after all expected stores", ram_req.store,
                 ram_req.addr);
        errors++;
      end else begin
        ea = exp_addr.pop_front();
        ed = exp_data.pop_front();
        en = exp_name.pop_front();
        assert (ram_req.addr == ea && ram_req.store == ed) else begin
          $display("FAIL %s: expected %h at %h, actual %h at %h", en, ed, ea,
                   ram_req.store, ram_req.addr);
          errors++;
        end
      end
    end
  end

  always @(posedge CLK) begin
    if (halt_seen) begin
      assert (halt === 1'b1) else begin
        $display("halt dropped after it was raised");
        errors++;
      end
      assert (!ram_req.wen) else begin
        $display("write request issued after halt");
        errors++;
      end
    end
    if (halt === 1'b1) begin
      halt_seen = 1'b1;
    end
  end

  initial begin
    nRST = 1'b0;
    build_program();
    ram0.fill();
    foreach (prog[i]) ram0.poke(i, prog[i]);
    timeout_cycles = prog.size() * 4 * MAX_DELAY + 500;
    repeat (5) begin
      @(posedge CLK);
      checks++;
      assert (!halt && !ram_req.wen && !dut0.dp0.dp_req.dmem_ren) else begin
        $display("halt, write or data read active during reset");
        errors++;
      end
    end
    @(negedge CLK);
    nRST = 1'b1;
    @(posedge CLK);
    checks++;
    assert (ram_req.ren && !ram_req.wen && !dut0.dp0.dp_req.dmem_ren &&
            ram_req.addr == 32'd0 && !halt) else begin
      $display("FAIL reset: expected fetch read of 00000000, actual ren %b wen %b addr %h",
               ram_req.ren, ram_req.wen, ram_req.addr);
      errors++;
    end
    wait (halt === 1'b1);
    repeat (20) @(posedge CLK);
    checks++;
    assert (exp_addr.size() == 0) else begin
      $display("%0d expected stores never appeared", exp_addr.size());
      errors++;
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== dv/tb_ram.sv ====
`timescale 1ns/10ps

module tb_ram
  import cpu_types_pkg::*;
  import pipe_types_pkg::*;
(
  input  logic     CLK,
  input  ram_req_t req,
  output word_t    load,
  output logic     ready
);

  localparam int MEM_WORDS = 1024;

  word_t       mem [MEM_WORDS];
  logic [15:0] lfsr = 16'd58;
  logic [1:0]  wait_cnt = '0;
  logic        busy = 1'b0;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // unused words hold an address pattern that decodes as no opcode
  task automatic fill();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hBAD0_0000 | (word_t'(i) << 2);
    end
  endtask

  task automatic poke(input int idx, input word_t w);
    mem[idx] = w;
  endtask

  initial begin
    ready = 1'b0;
    load  = '0;
  end

  // a new access waits 0 to 3 cycles drawn from two LFSR bits
  always @(negedge CLK) begin
    ready = 1'b0;
    if (req.ren || req.wen) begin
      if (!busy) begin
        busy        = 1'b1;
        wait_cnt[0] = lfsr[0];
        lfsr        = lfsr_next(lfsr);
        wait_cnt[1] = lfsr[0];
        lfsr        = lfsr_next(lfsr);
      end
      if (wait_cnt == 2'd0) begin
        ready = 1'b1;
        busy  = 1'b0;
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
    load = mem[req.addr[11:2]];
  end

  always @(posedge CLK) begin
    if (req.wen && ready) begin
      mem[req.addr[11:2]] = req.store;
    end
  end

endmodule

// ==== mips_pipe.f ====
design/cpu_types_pkg.sv
design/pipe_types_pkg.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/pipeline_reg.sv
design/datapath.sv
design/mem_arbiter.sv
design/mips_core.sv
dv/tb_ram.sv
dv/tb_mips_core.sv
